// File: hw/i2cPkg.sv
//----------------------------------------------------------------------
// Shared types and CSR map for the I2C keypad block
// Bus address word is {cmd, rsvd, blockAdrs, csrAdrs}, MSB first
// writeRead command (3) is decoded as unsupported and ignored
//----------------------------------------------------------------------
`default_nettype none

package i2cPkg;

	// Bus command in address bits 31:30
	typedef enum logic [1:0] {
		cmdNone      = 2'd0,
		cmdWrite     = 2'd1,
		cmdRead      = 2'd2,
		cmdWriteRead = 2'd3	// Not implemented
	} busCmd_e;

	typedef struct packed {
		busCmd_e     cmd;
		logic [5:0]  rsvd;		// Ignored
		logic [7:0]  blockAdrs;	// Which block on the bus
		logic [15:0] csrAdrs;	// Register inside the block
	} busAdrs_t;

	// CSR to reader config
	typedef struct packed {
		logic        enable;
		logic [15:0] div;		// Quarter bit = div+1 clocks
	} i2cCfg_t;

	// One keypad poll result, high byte first on the wire
	typedef struct packed {
		logic [15:0] keys;
	} keySample_t;

	//------------------------------------------------------------------
	// CSR offsets
	//------------------------------------------------------------------
	localparam logic [15:0] csrCtrl   = 16'h0000;	// bit0 enable
	localparam logic [15:0] csrDiv    = 16'h0004;
	localparam logic [15:0] csrData   = 16'h0008;	// Read pops FIFO
	localparam logic [15:0] csrStatus = 16'h000C;	// {nack, count}

	localparam logic [15:0] divDefault = 16'd24;	// Divider after reset

endpackage

`default_nettype wire

// File: hw/i2cKeypadReader.sv
//----------------------------------------------------------------------
// Polls one keypad with a two-byte I2C read, pushes each good sample
// No clock stretching, no repeated start, single master only
// sdaOe high pulls SDA low; the pull-up lives outside
// div of 0 leaves no margin for the mid-high sample, use 1 or more
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module i2cKeypadReader import i2cPkg::*; #(
	parameter logic [6:0] keypadAddr = 7'h20	// 7-bit device address
)(
	input  logic       sysClk,
	input  logic       rstN,
	input  i2cCfg_t    cfg,
	input  logic       full,		// FIFO full stalls the next poll
	output logic       scl,
	output logic       sdaOe,
	input  logic       sdaIn,
	output keySample_t pushData,
	output logic       push,
	output logic       nackPulse
);

typedef enum logic [3:0] {
	stIdle, stStart, stAddr, stAddrAck, stDataHi, stMack,
	stDataLo, stMnack, stStop, stGap
} state_e;

localparam logic [7:0] addrByte = {keypadAddr, 1'b1};	// Read bit set

state_e      state;
logic [1:0]  qtr;		// Quarter inside current bit
logic [2:0]  bitCnt;	// MSB first, counts down
logic [15:0] qCnt;
logic        tick;		// End of a quarter
logic        sampleTick;
logic        nacked;	// Address byte got no ACK
logic [1:0]  sdaSync;
logic        isBit;
logic        sclNext;
logic        sdaNext;

//----------------------------------------------------------------------
// Quarter-bit timebase
//----------------------------------------------------------------------
assign tick       = (qCnt >= cfg.div);	// >= covers a divider shrinking mid-count
assign sampleTick = tick && (qtr == 2'd2);	// Middle of SCL high

always_ff @(posedge sysClk)
begin
	if (!rstN)
		qCnt <= '0;
	else if (tick)
		qCnt <= '0;
	else
		qCnt <= qCnt + 16'd1;
end

// Two-flop sync, idles high like the bus
always_ff @(posedge sysClk)
begin
	if (!rstN)
		sdaSync <= 2'b11;
	else
		sdaSync <= {sdaSync[0], sdaIn};
end

//----------------------------------------------------------------------
// Pin levels per phase
//----------------------------------------------------------------------
assign isBit = (state inside {stAddr, stAddrAck, stDataHi, stMack, stDataLo, stMnack});

always_comb
begin
	case (state)
		stIdle, stStart, stGap: sclNext = 1'b1;
		default:                sclNext = qtr[1];	// Low half then high half
	endcase

	case (state)
		stStart: sdaNext = qtr[1];		// SDA falls while SCL high
		stAddr:  sdaNext = ~addrByte[bitCnt];
		stMack:  sdaNext = 1'b1;		// ACK the high byte
		stStop:  sdaNext = (qtr == 2'd1) || (qtr == 2'd2);	// Released at q3 is STOP
		default: sdaNext = 1'b0;		// Slave owns SDA or bus idle
	endcase
end

// Pins registered, so every edge lags state by one clock
always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		scl   <= 1'b1;
		sdaOe <= 1'b0;
	end
	else
	begin
		scl <= sclNext;
		if (!isBit || qtr == 2'd1)	// Data bits move SDA only well after SCL fell
			sdaOe <= sdaNext;
	end
end

//----------------------------------------------------------------------
// Transaction FSM
//----------------------------------------------------------------------
always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		state     <= stIdle;
		qtr       <= '0;
		bitCnt    <= '0;
		nacked    <= 1'b0;
		push      <= 1'b0;
		nackPulse <= 1'b0;
	end
	else
	begin
		push      <= 1'b0;
		nackPulse <= 1'b0;
		if (sampleTick && state == stAddrAck)
		begin
			nacked    <= sdaSync[1];	// High means no ACK
			nackPulse <= sdaSync[1];
		end
		if (tick)
		begin
			if (state != stIdle)
				qtr <= qtr + 2'd1;
			if (state == stIdle || qtr == 2'd3)
			begin
				case (state)
					stIdle:
						if (cfg.enable && !full)
						begin
							state  <= stStart;
							nacked <= 1'b0;
						end
					stStart:
					begin
						state  <= stAddr;
						bitCnt <= 3'd7;
					end
					stAddr:
						if (bitCnt == 3'd0)
							state <= stAddrAck;
						else
							bitCnt <= bitCnt - 3'd1;
					stAddrAck:
					begin
						state  <= nacked ? stStop : stDataHi;	// NACK goes straight to STOP
						bitCnt <= 3'd7;
					end
					stDataHi:
						if (bitCnt == 3'd0)
							state <= stMack;
						else
							bitCnt <= bitCnt - 3'd1;
					stMack:
					begin
						state  <= stDataLo;
						bitCnt <= 3'd7;
					end
					stDataLo:
						if (bitCnt == 3'd0)
							state <= stMnack;
						else
							bitCnt <= bitCnt - 3'd1;
					stMnack: state <= stStop;
					stStop:
					begin
						state <= stGap;
						push  <= !nacked;	// Lands the cycle after STOP
					end
					default: state <= stIdle;	// stGap, one idle SCL period
				endcase
			end
		end
	end
end

// Sample shift register, read by the FIFO only on push
always_ff @(posedge sysClk)
begin
	if (sampleTick && (state == stDataHi || state == stDataLo))
		pushData.keys <= {pushData.keys[14:0], sdaSync[1]};
end

endmodule

`default_nettype wire

// File: hw/sampleFifo.sv
//----------------------------------------------------------------------
// Synchronous FIFO, head entry always visible on popData
// Push when full and pop when empty are dropped silently
// depth must stay below 256 for the 8-bit count
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module sampleFifo #(
	parameter int  depth     = 8,
	parameter type payload_t = logic [15:0]
)(
	input  logic       sysClk,
	input  logic       rstN,
	input  logic       push,
	input  payload_t   pushData,
	input  logic       pop,
	output payload_t   popData,
	output logic       full,
	output logic       empty,
	output logic [7:0] count
);

localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

payload_t        mem [depth];
logic [ptrW-1:0] wrPtr;
logic [ptrW-1:0] rdPtr;
logic            doPush;
logic            doPop;

assign full    = (count == 8'(depth));
assign empty   = (count == 8'd0);
assign doPush  = push && !full;
assign doPop   = pop && !empty;
assign popData = mem[rdPtr];	// First-word fall-through

// Storage
always_ff @(posedge sysClk)
begin
	if (doPush)
		mem[wrPtr] <= pushData;
end

// Pointers wrap at depth, not at a power of two
always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end
	else
	begin
		if (doPush)
			wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
		if (doPop)
			rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
		if (doPush && !doPop)
			count <= count + 8'd1;
		else if (doPop && !doPush)
			count <= count - 8'd1;	// Both at once keeps the count
	end
end

endmodule

`default_nettype wire

// File: hw/i2cCsr.sv
//----------------------------------------------------------------------
// Bus slave for the keypad block: ctrl, divider, data and status
// Read data valid one clock after wCke, no back-pressure
// A data read pops the FIFO in the cycle it is accepted
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module i2cCsr import i2cPkg::*; #(
	parameter logic [7:0] blockAdrs = 8'h04	// Block address on the bus
)(
	input  logic        sysClk,
	input  logic        rstN,
	// Bus slave
	input  busAdrs_t    adrs,
	input  logic [31:0] wData,
	input  logic        wCke,
	output logic [31:0] rdData,
	output logic        rdValid,
	// Reader side
	output i2cCfg_t     cfg,
	input  logic        nackPulse,
	// FIFO side
	input  keySample_t  popData,
	input  logic        empty,
	input  logic [7:0]  count,
	output logic        pop
);

logic hit;
logic wrHit;
logic rdHit;
logic nackSticky;

//----------------------------------------------------------------------
// Decode
//----------------------------------------------------------------------
assign hit   = wCke && (adrs.blockAdrs == blockAdrs);
assign wrHit = hit && (adrs.cmd == cmdWrite);
assign rdHit = hit && (adrs.cmd == cmdRead);	// writeRead never matches
assign pop   = rdHit && (adrs.csrAdrs == csrData) && !empty;

// Control registers
always_ff @(posedge sysClk)
begin
	if (!rstN)
		cfg <= '{enable: 1'b0, div: divDefault};
	else if (wrHit)
	begin
		case (adrs.csrAdrs)
			csrCtrl: cfg.enable <= wData[0];
			csrDiv:  cfg.div    <= wData[15:0];
			default: ;	// Data and status have no plain write
		endcase
	end
end

// Sticky NACK, a new NACK wins over a clear in the same cycle
always_ff @(posedge sysClk)
begin
	if (!rstN)
		nackSticky <= 1'b0;
	else if (nackPulse)
		nackSticky <= 1'b1;
	else if (wrHit && adrs.csrAdrs == csrStatus && wData[8])
		nackSticky <= 1'b0;
end

//----------------------------------------------------------------------
// Read path
//----------------------------------------------------------------------
always_ff @(posedge sysClk)
begin
	if (!rstN)
		rdValid <= 1'b0;
	else
		rdValid <= rdHit;	// Exactly one cycle per read
end

always_ff @(posedge sysClk)
begin
	if (rdHit)
	begin
		case (adrs.csrAdrs)
			csrCtrl:   rdData <= {31'd0, cfg.enable};
			csrDiv:    rdData <= {16'd0, cfg.div};
			csrData:   rdData <= empty ? 32'd0 : {15'd0, 1'b1, popData.keys};	// bit16 was valid
			csrStatus: rdData <= {23'd0, nackSticky, count};
			default:   rdData <= 32'd0;	// Unmapped reads as zero
		endcase
	end
end

endmodule

`default_nettype wire

// File: hw/i2cBlock.sv
//----------------------------------------------------------------------
// I2C keypad poller on the on-chip bus: reader, sample FIFO, CSR
// SDA split into sdaIn and sdaOe, pull-up and wired-AND are external
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module i2cBlock import i2cPkg::*; #(
	parameter logic [7:0] blockAdrs  = 8'h04,
	parameter logic [6:0] keypadAddr = 7'h20,
	parameter int         fifoDepth  = 8
)(
	input  logic        sysClk,
	input  logic        rstN,
	// Bus slave
	input  busAdrs_t    adrs,
	input  logic [31:0] wData,
	input  logic        wCke,
	output logic [31:0] rdData,
	output logic        rdValid,
	// I2C pins
	output logic        scl,
	output logic        sdaOe,
	input  logic        sdaIn
);

i2cCfg_t    cfg;
keySample_t pushData;
keySample_t popData;
logic       push;
logic       pop;
logic       full;
logic       empty;
logic       nackPulse;
logic [7:0] count;

//----------------------------------------------------------------------
// Producer, buffer, consumer
//----------------------------------------------------------------------
i2cKeypadReader #(
	.keypadAddr	(keypadAddr)
) u_reader (
	.sysClk		(sysClk),
	.rstN		(rstN),
	.cfg		(cfg),
	.full		(full),
	.scl		(scl),
	.sdaOe		(sdaOe),
	.sdaIn		(sdaIn),
	.pushData	(pushData),
	.push		(push),
	.nackPulse	(nackPulse)
);

sampleFifo #(
	.depth		(fifoDepth),
	.payload_t	(keySample_t)
) u_fifo (
	.sysClk		(sysClk),
	.rstN		(rstN),
	.push		(push),
	.pushData	(pushData),
	.pop		(pop),
	.popData	(popData),
	.full		(full),
	.empty		(empty),
	.count		(count)
);

i2cCsr #(
	.blockAdrs	(blockAdrs)
) u_csr (
	.sysClk		(sysClk),
	.rstN		(rstN),
	.adrs		(adrs),
	.wData		(wData),
	.wCke		(wCke),
	.rdData		(rdData),
	.rdValid	(rdValid),
	.cfg		(cfg),
	.nackPulse	(nackPulse),
	.popData	(popData),
	.empty		(empty),
	.count		(count),
	.pop		(pop)
);

endmodule

`default_nettype wire

// File: test/i2cKeypadModel.sv
//----------------------------------------------------------------------
// Behavioral I2C keypad slave, answers two-byte reads only
// Sends txValue high byte first, served counts fully sent reads
// No clock stretching, STOP is not checked, sda is the wired-AND line
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module i2cKeypadModel #(
	parameter logic [6:0] keypadAddr = 7'h20
)(
	input  logic        scl,
	input  logic        sdaOe,		// Master pulls SDA low
	output logic        sda,		// Resolved bus line
	input  logic        nackMode,	// Leave the address unacked
	input  logic [15:0] txValue,
	output logic [31:0] served
);

logic drvLow;

assign sda = !(sdaOe || drvLow);	// Pull-up, either side pulls low

// One transaction after START, data changes only while scl is low
task automatic serveRead();
	logic [7:0]  addr;
	logic [15:0] value;
	int          i;
	addr = '0;
	repeat (8)
	begin
		@(posedge scl);
		addr = {addr[6:0], sda};	// Address and R/W, MSB first
	end
	@(negedge scl);
	if (addr == {keypadAddr, 1'b1} && !nackMode)
	begin
		drvLow = 1'b1;	// Address ACK
		value  = txValue;
		@(negedge scl);
		for (i = 15; i >= 0; i--)
		begin
			drvLow = !value[i];
			@(negedge scl);
			if (i == 8)
			begin
				drvLow = 1'b0;	// Master ACK slot
				@(negedge scl);
			end
		end
		drvLow = 1'b0;	// Master NACK slot, then STOP
		served = served + 32'd1;
	end
endtask

initial
begin
	drvLow = 1'b0;
	served = '0;
	forever
	begin
		@(negedge sda);
		if (scl)	// SDA falling with SCL high is START
			serveRead();
	end
end

endmodule

`default_nettype wire

// File: test/tbI2cBlock.sv
//----------------------------------------------------------------------
// Testbench for the I2C keypad block with a behavioral slave
// Divider runs at 3, so one SCL period is 16 clocks
// Keypad values come from an LFSR table, taken in poll order
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module tbI2cBlock import i2cPkg::*; ();

localparam logic [7:0]  blkAdrs     = 8'h04;
localparam logic [6:0]  devAddr     = 7'h20;
localparam int          depth       = 8;
localparam logic [15:0] divFast     = 16'd3;
localparam int          sclClocks   = 4 * (divFast + 1);	// One SCL period in clocks
localparam int          busTimeout  = 8;
localparam int          pollReads   = 4000;
localparam int          idleTimeout = 20000;

logic        sysClk;
logic        rstN;
busAdrs_t    adrs;
logic [31:0] wData;
logic        wCke;
logic [31:0] rdData;
logic        rdValid;
logic        scl;
logic        sdaOe;
logic        sda;
logic        nackMode;
logic [15:0] txValue;
logic [31:0] served;
logic [15:0] supply [64];	// Values in the order the keypad gives them
logic [31:0] lfsr;
int          readIdx;		// Next expected entry of supply

assign txValue = supply[served[5:0]];

i2cBlock #(
	.blockAdrs	(blkAdrs),
	.keypadAddr	(devAddr),
	.fifoDepth	(depth)
) u_dut (
	.sysClk		(sysClk),
	.rstN		(rstN),
	.adrs		(adrs),
	.wData		(wData),
	.wCke		(wCke),
	.rdData		(rdData),
	.rdValid	(rdValid),
	.scl		(scl),
	.sdaOe		(sdaOe),
	.sdaIn		(sda)
);

i2cKeypadModel #(
	.keypadAddr	(devAddr)
) u_keypad (
	.scl		(scl),
	.sdaOe		(sdaOe),
	.sda		(sda),
	.nackMode	(nackMode),
	.txValue	(txValue),
	.served		(served)
);

initial
begin
	sysClk = 1'b0;
	forever #2 sysClk = !sysClk;
end

//----------------------------------------------------------------------
// Helpers
//----------------------------------------------------------------------
task automatic abortRun();
	$display("=== FAIL ===");
	$fatal(1, "run stopped at the first error");
endtask

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp)
	else
	begin
		$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		abortRun();
	end
endtask

// Galois form, x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic drawKeys(output logic [15:0] v);
	int i;
	v = '0;
	for (i = 0; i < 16; i++)
	begin
		lfsr = lfsrNext(lfsr);	// One step per bit
		v    = {v[14:0], lfsr[0]};
	end
endtask

// One bus command, wCke high for a single cycle
task automatic busIssue(input busCmd_e cmd, input logic [7:0] blk,
	input logic [15:0] csr, input logic [31:0] data);
	@(posedge sysClk);
	adrs.cmd       <= cmd;
	adrs.rsvd      <= '0;
	adrs.blockAdrs <= blk;
	adrs.csrAdrs   <= csr;
	wData          <= data;
	wCke           <= 1'b1;
	@(posedge sysClk);
	wCke <= 1'b0;	// Command sampled on this edge
endtask

task automatic busWrite(input logic [15:0] csr, input logic [31:0] data);
	busIssue(cmdWrite, blkAdrs, csr, data);
endtask

task automatic busRead(input logic [15:0] csr, output logic [31:0] data);
	int waited;
	busIssue(cmdRead, blkAdrs, csr, 32'd0);
	waited = 0;
	do
	begin
		@(negedge sysClk);
		waited++;
	end
	while (!rdValid && waited < busTimeout);
	assert (rdValid)
	else
	begin
		$display("timeout, no read data for register 0x%h", csr);
		abortRun();
	end
	checkEq("rdValid delay", waited, 1);	// Valid right after the wCke edge
	data = rdData;
	@(negedge sysClk);
	checkEq("rdValid", 32'(rdValid), 32'd0);	// Single-cycle pulse
endtask

// Ignored commands must stay silent on the read port
task automatic expectSilence();
	repeat (4)
	begin
		@(negedge sysClk);
		checkEq("rdValid", 32'(rdValid), 32'd0);
	end
endtask

task automatic waitStatus(input logic [31:0] mask, input logic [31:0] value);
	logic [31:0] st;
	int          tries;
	st    = '0;
	tries = 0;
	do
	begin
		busRead(csrStatus, st);
		tries++;
	end
	while ((st & mask) != value && tries < pollReads);
	assert ((st & mask) == value)
	else
	begin
		$display("timeout, status never showed 0x%h under mask 0x%h", value, mask);
		abortRun();
	end
endtask

// Clocks until the next SCL falling edge
task automatic waitSclFall(output int clocks);
	logic prev;
	logic fell;
	clocks = 0;
	fell   = 1'b0;
	prev   = scl;
	while (!fell && clocks < idleTimeout)
	begin
		@(negedge sysClk);
		clocks++;
		fell = prev && !scl;
		prev = scl;
	end
	assert (fell)
	else
	begin
		$display("timeout, SCL never fell");
		abortRun();
	end
endtask

// Idle once SCL has stayed high far longer than gap plus START
task automatic waitBusIdle();
	int high;
	int clocks;
	high   = 0;
	clocks = 0;
	while (high < 6 * sclClocks && clocks < idleTimeout)
	begin
		@(negedge sysClk);
		clocks++;
		high = scl ? high + 1 : 0;
	end
	assert (high >= 6 * sclClocks)
	else
	begin
		$display("timeout, I2C bus did not go idle");
		abortRun();
	end
endtask

task automatic drainSamples(input int n);
	logic [31:0] d;
	repeat (n)
	begin
		busRead(csrData, d);
		checkEq("rdData", d, {15'd0, 1'b1, supply[readIdx]});	// bit16 marks valid
		readIdx++;
	end
endtask

//----------------------------------------------------------------------
// Stimulus
//----------------------------------------------------------------------
initial
begin
	logic [31:0] d;
	logic [15:0] v;
	int          period;
	int          i;
	rstN     = 1'b0;
	adrs     = '0;
	wData    = '0;
	wCke     = 1'b0;
	nackMode = 1'b0;
	readIdx  = 0;
	lfsr     = 32'h1bb66dd3;
	for (i = 0; i < 64; i++)
	begin
		drawKeys(v);
		supply[i] = v;
	end
	repeat (3) @(posedge sysClk);
	rstN <= 1'b1;
	@(negedge sysClk);
	checkEq("scl", 32'(scl), 32'd1);	// Bus idle after reset
	checkEq("sdaOe", 32'(sdaOe), 32'd0);

	busRead(csrCtrl, d);
	checkEq("ctrl", d, 32'd0);
	busRead(csrDiv, d);
	checkEq("div", d, 32'd24);
	busRead(csrStatus, d);
	checkEq("status", d, 32'd0);

	// Register access and decode
	busWrite(csrDiv, 32'(divFast));
	busRead(csrDiv, d);
	checkEq("div", d, 32'(divFast));
	busIssue(cmdWrite, blkAdrs + 8'd1, csrDiv, 32'h55);	// Other block
	expectSilence();
	busIssue(cmdRead, blkAdrs + 8'd1, csrDiv, 32'd0);
	expectSilence();
	busIssue(cmdNone, blkAdrs, csrDiv, 32'h55);
	expectSilence();
	busIssue(cmdWriteRead, blkAdrs, csrCtrl, 32'd1);	// Unsupported
	expectSilence();
	busRead(csrDiv, d);
	checkEq("div", d, 32'(divFast));
	busRead(csrCtrl, d);
	checkEq("ctrl", d, 32'd0);

	// SCL timing inside the address byte
	busWrite(csrCtrl, 32'd1);
	busRead(csrCtrl, d);
	checkEq("ctrl", d, 32'd1);
	waitSclFall(period);	// First address bit
	repeat (4)
	begin
		waitSclFall(period);
		checkEq("scl period", period, sclClocks);
	end

	// Sample path
	waitStatus(32'hFF, 32'd4);
	busWrite(csrCtrl, 32'd0);	// Current poll still finishes
	waitBusIdle();
	busRead(csrStatus, d);
	assert (d[7:0] >= 8'd4)
	else
	begin
		$display("ERR count 0x%h below 0x04", d[7:0]);
		abortRun();
	end
	drainSamples(int'(d[7:0]));
	busRead(csrData, d);
	checkEq("rdData", d, 32'd0);	// Empty FIFO, bit16 clear
	checkEq("served", served, readIdx);

	// NACK
	@(posedge sysClk);
	nackMode <= 1'b1;
	busWrite(csrCtrl, 32'd1);
	waitStatus(32'h100, 32'h100);
	busWrite(csrCtrl, 32'd0);
	waitBusIdle();
	busRead(csrStatus, d);
	checkEq("status", d, 32'h100);	// Sticky bit, no samples
	busWrite(csrStatus, 32'h100);
	busRead(csrStatus, d);
	checkEq("status", d, 32'd0);
	@(posedge sysClk);
	nackMode <= 1'b0;

	// Back-pressure from a full FIFO
	busWrite(csrCtrl, 32'd1);
	waitStatus(32'hFF, depth);
	repeat (4 * 30 * sclClocks)	// About four poll intervals
	begin
		@(negedge sysClk);
		checkEq("scl", 32'(scl), 32'd1);
	end
	busRead(csrStatus, d);
	checkEq("status", d, depth);
	drainSamples(1);
	waitStatus(32'hFF, depth);	// Polling resumed
	busWrite(csrCtrl, 32'd0);
	waitBusIdle();
	drainSamples(depth);
	busRead(csrData, d);
	checkEq("rdData", d, 32'd0);
	checkEq("served", served, readIdx);	// Nothing lost

	$display("=== PASS ===");
	$finish;
end

endmodule

`default_nettype wire

// File: project.f
hw/i2cPkg.sv
hw/i2cKeypadReader.sv
hw/sampleFifo.sv
hw/i2cCsr.sv
hw/i2cBlock.sv
test/i2cKeypadModel.sv
test/tbI2cBlock.sv

// File: run.sh
#!/bin/sh
# Build and run the keypad block testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tbI2cBlock -f project.f
out=$(./obj_dir/VtbI2cBlock 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '=== PASS ==='
then
	exit 0
fi
exit 1
